//--- verilog/qsched_defs.svh
// queue scheduler sizing
// requestor count, queue id and counter widths shared by the package and the RTL

`ifndef QSCHED_DEFS_SVH
`define QSCHED_DEFS_SVH

// number of enqueue FIFOs, which is also the number of arbiter requestors
`define QS_NUM_REQS 4

// width of a requestor index
`define QS_REQ_W 2

// queue id width, one state counter per id
`define QS_QID_W 5

// entries held by each enqueue FIFO
`define QS_FIFO_DEPTH 4

// per-qid counter width, the counters wrap
`define QS_CNT_W 8

// width of the sequence tag carried by every request
`define QS_TAG_W 8

// width of the stall limit input and of the stall counter
`define QS_STALL_W 3

`endif

//--- verilog/qsched_pkg.sv
// queue scheduler types
// opcodes, pipeline stage names and the request and completion records

`include "qsched_defs.svh"

`default_nettype none

package qsched_pkg;

  // update applied to the counter of the addressed qid
  typedef enum logic {
    OP_INC = 1'b0,
    OP_DEC = 1'b1
  } qs_op_e;

  // stages of the read-modify-write pipeline, also used as record index
  typedef enum logic [1:0] {
    STG_RD  = 2'd0,
    STG_MOD = 2'd1,
    STG_WR  = 2'd2
  } qs_stage_e;

  // one enqueue request as pushed into a FIFO
  typedef struct packed {
    logic [`QS_QID_W-1:0] qid;
    qs_op_e               op;
    logic [`QS_TAG_W-1:0] tag;
  } qs_req_t;

  // a retired request with its source FIFO and the counter value it produced
  typedef struct packed {
    logic [`QS_QID_W-1:0] qid;
    qs_op_e               op;
    logic [`QS_TAG_W-1:0] tag;
    logic [`QS_REQ_W-1:0] src;
    logic [`QS_CNT_W-1:0] count;
  } qs_cmpl_t;

endpackage

`default_nettype wire

//--- verilog/enq_fifo.sv
// enqueue FIFO
// circular buffer of requests that shows its oldest entry at the head

`include "qsched_defs.svh"

`default_nettype none

module enq_fifo (
  input  wire                 clk,
  input  wire                 rst_n,
  input  logic                push,
  input  qsched_pkg::qs_req_t push_req,
  input  logic                pop,
  output qsched_pkg::qs_req_t head,
  output logic                not_empty,
  output logic                full
);
  import qsched_pkg::*;

  localparam int DEPTH = `QS_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int OCC_W = $clog2(DEPTH + 1);

  // request storage addressed by the two pointers
  qs_req_t           mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [OCC_W-1:0]  occ;
  logic              push_ok;
  logic              pop_ok;

  // a push into a full FIFO is dropped even if a pop happens in the same cycle
  assign push_ok = push & ~full;
  // pop comes from a grant, which only goes to a FIFO holding data
  assign pop_ok  = pop & not_empty;

  assign head      = mem[rd_ptr];
  assign not_empty = (occ != '0);
  assign full      = (occ == OCC_W'(DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (push_ok) begin
        // wrap explicitly so depths other than a power of two also work
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the occupancy unchanged
      if (push_ok && !pop_ok) begin
        occ <= occ + 1'b1;
      end else if (pop_ok && !push_ok) begin
        occ <= occ - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_req;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rr_arb.sv
// round-robin arbiter
// picks the first active requestor after the last one served

`include "qsched_defs.svh"

`default_nettype none

module rr_arb (
  input  wire                        clk,
  input  wire                        rst_n,
  input  logic [`QS_NUM_REQS-1:0]    reqs,
  input  logic                       update,
  output logic                       winner_v,
  output logic [`QS_REQ_W-1:0]       winner
);

  localparam int NUM_REQS = `QS_NUM_REQS;
  localparam int REQ_W    = `QS_REQ_W;

  // index of the requestor served last, the search starts just past it
  logic [REQ_W-1:0] last_q;

  always_comb begin
    int idx;
    winner_v = 1'b0;
    winner   = '0;
    idx      = 0;
    // walk the ring once and keep the first hit
    for (int off = 1; off <= NUM_REQS; off++) begin
      idx = (int'(last_q) + off) % NUM_REQS;
      if (!winner_v && reqs[idx]) begin
        winner_v = 1'b1;
        winner   = REQ_W'(idx);
      end
    end
  end

  // starting at the last requestor makes requestor 0 the first choice out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= REQ_W'(NUM_REQS - 1);
    end else if (update && winner_v) begin
      // the ring only advances when the result was actually used
      last_q <= winner;
    end
  end

endmodule

`default_nettype wire

//--- verilog/enq_arb.sv
// collision-aware enqueue arbiter
// a high-priority round-robin arbiter sees every requestor, an alternate one
// sees only those without a pipeline collision, and a stall counter bounds how
// long a colliding high-priority requestor can be passed over

`include "qsched_defs.svh"

`default_nettype none

module enq_arb (
  input  wire                        clk,
  input  wire                        rst_n,
  input  logic [`QS_STALL_W-1:0]     stall_limit,
  input  logic [`QS_NUM_REQS-1:0]    reqs,
  input  logic [`QS_NUM_REQS-1:0]    mask,
  input  logic                       update,
  output logic                       winner_v,
  output logic [`QS_REQ_W-1:0]       winner
);

  localparam int STALL_W = `QS_STALL_W;

  logic                       hp_winner_v;
  logic [`QS_REQ_W-1:0]       hp_winner;
  logic                       hp_update;
  logic                       alt_winner_v;
  logic [`QS_REQ_W-1:0]       alt_winner;
  logic [`QS_NUM_REQS-1:0]    alt_reqs;
  logic                       alt_update;
  logic                       hp_masked;

  logic [STALL_W-1:0]         stall_q;
  logic [STALL_W-1:0]         stall_nxt;
  logic [STALL_W:0]           stall_sum;
  logic                       max_q;
  logic                       max_nxt;

  // the high-priority ring sees everything that has work
  rr_arb hp_arb_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .reqs     (reqs),
    .update   (hp_update),
    .winner_v (hp_winner_v),
    .winner   (hp_winner)
  );

  // a set mask bit means the head qid is already in flight, so the alternate
  // ring only considers heads that would not collide
  assign alt_reqs = reqs & ~mask;

  rr_arb alt_arb_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .reqs     (alt_reqs),
    .update   (alt_update),
    .winner_v (alt_winner_v),
    .winner   (alt_winner)
  );

  assign hp_masked = hp_winner_v & mask[hp_winner];
  // one extra bit so the compare works when the limit is at its maximum
  assign stall_sum = {1'b0, stall_q} + 1'b1;

  always_comb begin
    // default is the high-priority choice with the stall state cleared
    winner_v   = hp_winner_v;
    winner     = hp_winner;
    hp_update  = update;
    alt_update = 1'b0;
    stall_nxt  = '0;
    max_nxt    = 1'b0;
    // pass a colliding head over only while it has not waited too long
    if (hp_masked && alt_winner_v && !max_q) begin
      winner_v   = alt_winner_v;
      winner     = alt_winner;
      hp_update  = 1'b0;
      alt_update = update;
      stall_nxt  = stall_sum[STALL_W-1:0];
      // once the count passes the limit the next grant is forced to hp
      max_nxt    = (stall_sum > {1'b0, stall_limit});
    end
  end

  // the hp pointer stays put while the alternate ring serves, so the stalled
  // requestor remains the high-priority one until it is finally granted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q <= '0;
      max_q   <= 1'b0;
    end else if (update) begin
      stall_q <= stall_nxt;
      max_q   <= max_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/qstate_pipe.sv
// per-qid state pipeline
// three-stage read-modify-write over the qid counters with result forwarding,
// plus the collision mask that tells the arbiter which heads are in flight

`include "qsched_defs.svh"

`default_nettype none

module qstate_pipe (
  input  wire                    clk,
  input  wire                    rst_n,
  input  logic                   in_v,
  input  qsched_pkg::qs_req_t    in_req,
  input  logic [`QS_REQ_W-1:0]   in_src,
  input  qsched_pkg::qs_req_t    heads [`QS_NUM_REQS],
  output logic [`QS_NUM_REQS-1:0] collide,
  output logic                   cmpl_v,
  output qsched_pkg::qs_cmpl_t   cmpl
);
  import qsched_pkg::*;

  localparam int NUM_Q    = 1 << `QS_QID_W;
  localparam int NUM_STG  = 3;
  localparam int NUM_REQS = `QS_NUM_REQS;

  // counter memory, cleared on reset so every qid starts at zero
  logic [`QS_CNT_W-1:0] mem [NUM_Q];

  // stage records, indexed by the stage enum
  logic [NUM_STG-1:0]   stg_v;
  qs_cmpl_t             stg [NUM_STG];

  qs_cmpl_t             rd_nxt;
  qs_cmpl_t             mod_nxt;
  logic [`QS_CNT_W-1:0] mod_base;

  // a new entry starts with a blank count, RD fills it in below
  always_comb begin
    rd_nxt = '{qid:   in_req.qid,
               op:    in_req.op,
               tag:   in_req.tag,
               src:   in_src,
               count: '0};
  end

  // MOD picks the freshest value of its qid
  always_comb begin
    mod_nxt = stg[STG_MOD];
    // the entry MOD finished last cycle sits in WR and is not yet in memory
    if (stg_v[STG_WR] && (stg[STG_WR].qid == stg[STG_MOD].qid)) begin
      mod_base = stg[STG_WR].count;
    // the entry WR retired at the last edge was written after RD read memory
    end else if (cmpl_v && (cmpl.qid == stg[STG_MOD].qid)) begin
      mod_base = cmpl.count;
    end else begin
      mod_base = stg[STG_MOD].count;
    end
    if (stg[STG_MOD].op == OP_INC) begin
      mod_nxt.count = mod_base + 1'b1;
    end else begin
      mod_nxt.count = mod_base - 1'b1;
    end
  end

  // a head collides when its qid matches any valid stage, empty FIFOs are
  // filtered out by the arbiter's request vector
  always_comb begin
    collide = '0;
    for (int i = 0; i < NUM_REQS; i++) begin
      for (int s = 0; s < NUM_STG; s++) begin
        if (stg_v[s] && (stg[s].qid == heads[i].qid)) begin
          collide[i] = 1'b1;
        end
      end
    end
  end

  // valid bits, completion strobe and the memory write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_v  <= '0;
      cmpl_v <= 1'b0;
      for (int q = 0; q < NUM_Q; q++) begin
        mem[q] <= '0;
      end
    end else begin
      stg_v[STG_RD]  <= in_v;
      stg_v[STG_MOD] <= stg_v[STG_RD];
      stg_v[STG_WR]  <= stg_v[STG_MOD];
      // WR writes back and retires in the same edge
      cmpl_v         <= stg_v[STG_WR];
      if (stg_v[STG_WR]) begin
        mem[stg[STG_WR].qid] <= stg[STG_WR].count;
      end
    end
  end

  // payload follows the valid bits down the pipeline
  always_ff @(posedge clk) begin
    stg[STG_RD]  <= rd_nxt;
    // RD reads memory here, MOD may still replace the value by forwarding
    stg[STG_MOD] <= '{qid:   stg[STG_RD].qid,
                      op:    stg[STG_RD].op,
                      tag:   stg[STG_RD].tag,
                      src:   stg[STG_RD].src,
                      count: mem[stg[STG_RD].qid]};
    stg[STG_WR]  <= mod_nxt;
    cmpl         <= stg[STG_WR];
  end

endmodule

`default_nettype wire

//--- verilog/qsched_top.sv
// atomic queue enqueue scheduler
// four enqueue FIFOs share the qid state pipeline through the collision-aware
// arbiter, and every grant retires three cycles later

`include "qsched_defs.svh"

`default_nettype none

module qsched_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  logic [`QS_STALL_W-1:0]     stall_limit,
  input  logic [`QS_NUM_REQS-1:0]    push,
  input  qsched_pkg::qs_req_t        push_req [`QS_NUM_REQS],
  output logic [`QS_NUM_REQS-1:0]    full,
  output logic                       cmpl_v,
  output qsched_pkg::qs_cmpl_t       cmpl
);
  import qsched_pkg::*;

  qs_req_t                    heads [`QS_NUM_REQS];
  logic [`QS_NUM_REQS-1:0]    not_empty;
  logic [`QS_NUM_REQS-1:0]    collide;
  logic [`QS_NUM_REQS-1:0]    grant;
  logic                       winner_v;
  logic [`QS_REQ_W-1:0]       winner;

  for (genvar g = 0; g < `QS_NUM_REQS; g++) begin : gen_fifo
    enq_fifo enq_fifo_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push[g]),
      .push_req  (push_req[g]),
      .pop       (grant[g]),
      .head      (heads[g]),
      .not_empty (not_empty[g]),
      .full      (full[g])
    );
  end

  // one-hot pop for the granted FIFO
  always_comb begin
    grant = '0;
    if (winner_v) begin
      grant[winner] = 1'b1;
    end
  end

  // the pipeline never stalls, so every selection is consumed at once
  enq_arb enq_arb_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_limit (stall_limit),
    .reqs        (not_empty),
    .mask        (collide),
    .update      (winner_v),
    .winner_v    (winner_v),
    .winner      (winner)
  );

  qstate_pipe qstate_pipe_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_v    (winner_v),
    .in_req  (heads[winner]),
    .in_src  (winner),
    .heads   (heads),
    .collide (collide),
    .cmpl_v  (cmpl_v),
    .cmpl    (cmpl)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// testbench clock source
// free-running clock with a configurable period

`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- tests/qsched_tb.sv
// queue scheduler testbench
// drives the four enqueue FIFOs, mirrors counters and request order in a model,
// and checks completions, stall bound and work conservation with assertions

`include "qsched_defs.svh"

`default_nettype none

module qsched_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import qsched_pkg::*;

  localparam int NUM_REQS   = `QS_NUM_REQS;
  localparam int NUM_Q      = 1 << `QS_QID_W;
  localparam int DEPTH      = `QS_FIFO_DEPTH;
  localparam int RING       = 256;
  localparam int MAX_CYCLES = 4000;

  logic                    clk;
  logic                    rst_n;
  logic [`QS_STALL_W-1:0]  stall_limit;
  logic [NUM_REQS-1:0]     push;
  qs_req_t                 push_req [NUM_REQS];
  logic [NUM_REQS-1:0]     full;
  logic                    cmpl_v;
  qs_cmpl_t                cmpl;

  // reference model state
  logic [`QS_CNT_W-1:0]    cnt_model [NUM_Q];
  qs_req_t                 req_q [NUM_REQS][RING];
  int                      wr_idx [NUM_REQS];
  int                      rd_idx [NUM_REQS];
  int                      wait_cnt [NUM_REQS];
  int                      occ_model;
  int                      refused;
  int                      cycles;
  logic [`QS_TAG_W-1:0]    next_tag [NUM_REQS];
  logic                    stall_check;
  qs_req_t                 exp_req;
  logic [`QS_CNT_W-1:0]    exp_count;
  logic                    src_pending;
  logic                    busy;
  int                      stall_bound;

  tb_clk_gen #(.PERIOD_NS(10.0)) clk_gen_i (.clk(clk));

  qsched_top qsched_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_limit (stall_limit),
    .push        (push),
    .push_req    (push_req),
    .full        (full),
    .cmpl_v      (cmpl_v),
    .cmpl        (cmpl)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    abort_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
  endtask

  function automatic int outstanding_total();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_REQS; i++) begin
      sum += wr_idx[i] - rd_idx[i];
    end
    return sum;
  endfunction

  // expected completion is the oldest request still held for the reported source
  always_comb begin
    exp_req     = req_q[cmpl.src][rd_idx[cmpl.src] % RING];
    src_pending = (wr_idx[cmpl.src] != rd_idx[cmpl.src]);
    if (exp_req.op == OP_INC) begin
      exp_count = cnt_model[exp_req.qid] + 1'b1;
    end else begin
      exp_count = cnt_model[exp_req.qid] - 1'b1;
    end
  end

  assign busy        = (occ_model > 0);
  assign stall_bound = NUM_REQS * (int'(stall_limit) + 2);

  // the model follows accepted pushes and completions edge by edge
  always @(posedge clk) begin
    int acc;
    int rej;
    if (!rst_n) begin
      for (int q = 0; q < NUM_Q; q++) begin
        cnt_model[q] <= '0;
      end
      for (int i = 0; i < NUM_REQS; i++) begin
        wr_idx[i]   <= 0;
        rd_idx[i]   <= 0;
        wait_cnt[i] <= 0;
      end
      occ_model <= 0;
      refused   <= 0;
    end else begin
      acc = 0;
      rej = 0;
      for (int i = 0; i < NUM_REQS; i++) begin
        if (push[i] && !full[i]) begin
          req_q[i][wr_idx[i] % RING] <= push_req[i];
          wr_idx[i] <= wr_idx[i] + 1;
          acc++;
        end else if (push[i]) begin
          rej++;
        end
        // completions by other FIFOs while this one still has work
        if (cmpl_v && (int'(cmpl.src) == i)) begin
          wait_cnt[i] <= 0;
        end else if (wr_idx[i] != rd_idx[i]) begin
          wait_cnt[i] <= wait_cnt[i] + (cmpl_v ? 1 : 0);
        end else begin
          wait_cnt[i] <= 0;
        end
      end
      if (cmpl_v) begin
        cnt_model[exp_req.qid] <= exp_count;
        rd_idx[cmpl.src]       <= rd_idx[cmpl.src] + 1;
      end
      refused <= refused + rej;
      // a non-empty set of FIFOs loses exactly one entry per cycle
      occ_model <= occ_model + acc - ((occ_model > 0) ? 1 : 0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      abort_run("timeout: the run did not finish within the cycle limit");
    end
  end

  a_reset: assert property (@(posedge clk) !rst_n |-> (full == '0 && !cmpl_v))
    else abort_run("full or cmpl_v was active during reset");

  a_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (full == '0 && !cmpl_v))
    else abort_run("full or cmpl_v was active right after reset");

  a_pending: assert property (@(posedge clk) disable iff (!rst_n) cmpl_v |-> src_pending)
    else abort_run("completion arrived for a FIFO with no outstanding request");

  a_count: assert property (@(posedge clk) disable iff (!rst_n)
                            cmpl_v |-> cmpl.count == exp_count)
    else report_mismatch("cmpl_count", $sampled(exp_count), $sampled(cmpl.count));

  a_qid: assert property (@(posedge clk) disable iff (!rst_n)
                          cmpl_v |-> cmpl.qid == exp_req.qid)
    else report_mismatch("cmpl_qid", $sampled(exp_req.qid), $sampled(cmpl.qid));

  a_op: assert property (@(posedge clk) disable iff (!rst_n)
                         cmpl_v |-> cmpl.op == exp_req.op)
    else report_mismatch("cmpl_op", $sampled(exp_req.op), $sampled(cmpl.op));

  a_tag: assert property (@(posedge clk) disable iff (!rst_n)
                          cmpl_v |-> cmpl.tag == exp_req.tag)
    else report_mismatch("cmpl_tag", $sampled(exp_req.tag), $sampled(cmpl.tag));

  // a FIFO with data before an edge is granted at it, and the completion is
  // sampled four edges on
  a_work: assert property (@(posedge clk) disable iff (!rst_n) busy |-> ##4 cmpl_v)
    else abort_run("no completion followed a cycle with a non-empty FIFO");

  for (genvar g = 0; g < NUM_REQS; g++) begin : gen_fifo_chk
    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
                              stall_check |-> wait_cnt[g] <= stall_bound)
      else report_mismatch($sformatf("stall_wait_%0d", g), $sampled(stall_bound),
                           $sampled(wait_cnt[g]));

    // a full FIFO holds DEPTH entries, and every one of them is still outstanding
    a_full: assert property (@(posedge clk) disable iff (!rst_n)
                             full[g] |-> (wr_idx[g] - rd_idx[g]) >= DEPTH)
      else abort_run($sformatf("FIFO %0d reported full with fewer than %0d requests held",
                               g, DEPTH));
  end

  // mode 0 random qids, mode 1 every FIFO on one qid, mode 2 one hot FIFO
  task automatic run_phase(input int n_cycles, input int mode);
    logic                 en;
    logic [`QS_QID_W-1:0] qid;
    for (int c = 0; c < n_cycles; c++) begin
      @(posedge clk);
      for (int i = 0; i < NUM_REQS; i++) begin
        case (mode)
          0: begin
            en  = (($urandom % 3) == 0);
            qid = `QS_QID_W'($urandom);
          end
          1: begin
            en  = 1'b1;
            qid = `QS_QID_W'(5);
          end
          default: begin
            en = (($urandom % 2) == 0);
            // consecutive pushes of a cold FIFO never reuse a qid in flight
            qid = (i == NUM_REQS - 1) ? `QS_QID_W'(NUM_Q - 1) :
                  `QS_QID_W'(8 * i + int'(next_tag[i]) % 8);
          end
        endcase
        push[i]     <= en;
        push_req[i] <= '{qid: qid, op: qs_op_e'($urandom % 2), tag: next_tag[i]};
        if (en) begin
          next_tag[i] = next_tag[i] + 1'b1;
        end
      end
    end
    @(posedge clk);
    push <= '0;
  endtask

  task automatic drain();
    do begin
      @(posedge clk);
    end while (outstanding_total() != 0 || occ_model != 0);
    repeat (4) @(posedge clk);
  endtask

  initial begin
    logic ok;
    void'($urandom(86));
    rst_n       = 1'b0;
    push        = '0;
    stall_limit = 3'd3;
    stall_check = 1'b0;
    cycles      = 0;
    for (int i = 0; i < NUM_REQS; i++) begin
      push_req[i] = '0;
      next_tag[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run_phase(400, 0);
    drain();
    // all FIFOs on one qid fills them up and forces forwarding
    run_phase(40, 1);
    drain();
    stall_limit <= 3'd0;
    stall_check <= 1'b1;
    run_phase(300, 2);
    drain();
    stall_limit <= 3'd7;
    run_phase(300, 2);
    drain();
    stall_check <= 1'b0;
    @(posedge clk);
    ok = (refused > 0) && (outstanding_total() == 0);
    if (ok) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("no push was refused or some accepted push never completed");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/qsched_pkg.sv
verilog/enq_fifo.sv
verilog/rr_arb.sv
verilog/enq_arb.sv
verilog/qstate_pipe.sv
verilog/qsched_top.sv
tests/tb_clk_gen.sv
tests/qsched_tb.sv

//--- Makefile
# Verilator build and run for the queue scheduler testbench

VERILATOR ?= verilator
TOP       ?= qsched_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
